// File: src/perf_cfg_pkg.sv
package perf_cfg_pkg;

  localparam int NUM_MGR    = 2;
  localparam int REG_ADDR_W = 4;
  localparam int REG_DATA_W = 32;
  localparam int STAT_W     = 32;

  // config register reset values
  localparam logic [7:0]  BEATS_RST  = 8'd16;
  localparam logic [15:0] BURSTS_RST = 16'd4;

  typedef enum logic [1:0] {
    RUN_IDLE,
    RUN_START,
    RUN_WAIT
  } run_state_e;

  typedef enum logic [REG_ADDR_W-1:0] {
    REG_START       = 4'd0,
    REG_IDLE        = 4'd1,
    REG_BURST_BEATS = 4'd2,
    REG_BURST_NUM   = 4'd3,
    REG_STAT_BURSTS = 4'd4,
    REG_STAT_BEATS  = 4'd5,
    REG_STAT_CYCLES = 4'd6
  } reg_id_e;

  typedef enum logic {
    OP_READ,
    OP_WRITE
  } reg_op_e;

  typedef enum logic {
    RSP_OK,
    RSP_ERR
  } reg_rsp_e;

  typedef struct packed {
    reg_op_e                 op;
    logic [REG_ADDR_W-1:0]   addr;
    logic [REG_DATA_W-1:0]   wdata;
  } reg_req_t;

  typedef struct packed {
    reg_rsp_e                code;
    logic [REG_DATA_W-1:0]   rdata;
  } reg_rsp_t;

  typedef struct packed {
    logic [7:0]  burst_beats;
    logic [15:0] burst_num;
  } gen_cfg_t;

  typedef struct packed {
    logic [STAT_W-1:0] bursts;
    logic [STAT_W-1:0] beats;
    logic [STAT_W-1:0] cycles;
  } run_stats_t;

endpackage

// File: src/axi_wr_pkg.sv
package axi_wr_pkg;

  localparam int AXI_ADDR_W = 20;
  localparam int AXI_DATA_W = 16;
  localparam int AXI_ID_W   = 4;

  // top id bit belongs to the arbiter
  localparam int MGR_ID_W = AXI_ID_W - 1;
  localparam int STRB_W   = AXI_DATA_W / 8;

  // size code for a full bus width beat
  localparam logic [2:0] MAX_AWSIZE = 3'($clog2(STRB_W));
  localparam logic [1:0] BURST_INCR = 2'b01;

  // ------------------------------
  // write channels
  // ------------------------------
  typedef struct packed {
    logic [AXI_ADDR_W-1:0] addr;
    logic [AXI_ID_W-1:0]   id;
    logic [7:0]            len;
    logic [2:0]            size;
    logic [1:0]            burst;
  } aw_beat_t;

  typedef struct packed {
    logic [AXI_DATA_W-1:0] data;
    logic [STRB_W-1:0]     strb;
    logic                  last;
  } w_beat_t;

  typedef struct packed {
    logic [AXI_ID_W-1:0] id;
    logic [1:0]          resp;
  } b_beat_t;

endpackage

// File: src/perf_ctrl_regs.sv
`timescale 1ns/1ps

module perf_ctrl_regs (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     i_reg_req,
  input  perf_cfg_pkg::reg_req_t   i_reg_req_data,
  output logic                     o_reg_ack,
  output perf_cfg_pkg::reg_rsp_t   o_reg_rsp,
  input  logic                     i_idle,
  input  perf_cfg_pkg::run_stats_t i_stats,
  output logic                     o_start,
  output perf_cfg_pkg::gen_cfg_t   o_cfg
);
  import perf_cfg_pkg::*;

  logic     pend;
  logic     start_flag;
  logic     start_ok;
  logic     wr_ok;
  logic     req_take;
  reg_req_t req_q;
  reg_rsp_t rsp_d;
  logic     wr_ok_d;
  logic     start_ok_d;

  // new request only once the previous ack has dropped
  assign req_take = i_reg_req && !o_reg_ack && !pend;

  // ------------------------------
  // decode
  // ------------------------------
  always_comb begin
    rsp_d      = '{code: RSP_OK, rdata: '0};
    wr_ok_d    = 1'b0;
    start_ok_d = 1'b0;
    if (i_reg_req_data.op == OP_READ) begin
      case (i_reg_req_data.addr)
        REG_START:       rsp_d.rdata = REG_DATA_W'(start_flag);
        // an accepted start counts as busy before the sequencer moves
        REG_IDLE:        rsp_d.rdata = REG_DATA_W'(i_idle && !start_flag);
        REG_BURST_BEATS: rsp_d.rdata = REG_DATA_W'(o_cfg.burst_beats);
        REG_BURST_NUM:   rsp_d.rdata = REG_DATA_W'(o_cfg.burst_num);
        REG_STAT_BURSTS: rsp_d.rdata = REG_DATA_W'(i_stats.bursts);
        REG_STAT_BEATS:  rsp_d.rdata = REG_DATA_W'(i_stats.beats);
        REG_STAT_CYCLES: rsp_d.rdata = REG_DATA_W'(i_stats.cycles);
        default:         rsp_d.code  = RSP_ERR;
      endcase
    end else begin
      case (i_reg_req_data.addr)
        REG_START: begin
          if (i_reg_req_data.wdata[0] && (!i_idle || start_flag)) begin
            rsp_d.code = RSP_ERR;
          end else begin
            start_ok_d = i_reg_req_data.wdata[0];
          end
        end
        REG_BURST_BEATS, REG_BURST_NUM: wr_ok_d = 1'b1;
        default: rsp_d.code = RSP_ERR;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pend       <= 1'b0;
      o_reg_ack  <= 1'b0;
      o_start    <= 1'b0;
      start_flag <= 1'b0;
      o_cfg      <= '{burst_beats: BEATS_RST, burst_num: BURSTS_RST};
    end else begin
      o_start <= 1'b0;
      if (start_flag && i_idle && !o_start) begin
        start_flag <= 1'b0;
      end
      if (req_take) begin
        pend <= 1'b1;
      end
      if (pend) begin
        // write takes effect with the ack
        pend      <= 1'b0;
        o_reg_ack <= 1'b1;
        o_start   <= start_ok;
        if (start_ok) begin
          start_flag <= 1'b1;
        end
        if (wr_ok && req_q.addr == REG_BURST_BEATS) begin
          o_cfg.burst_beats <= req_q.wdata[7:0];
        end
        if (wr_ok && req_q.addr == REG_BURST_NUM) begin
          o_cfg.burst_num <= req_q.wdata[15:0];
        end
      end else if (o_reg_ack && !i_reg_req) begin
        o_reg_ack <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req_take) begin
      req_q     <= i_reg_req_data;
      o_reg_rsp <= rsp_d;
      wr_ok     <= wr_ok_d;
      start_ok  <= start_ok_d;
    end
  end

endmodule

// File: src/perf_sequencer.sv
`timescale 1ns/1ps

module perf_sequencer (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             i_start,
  input  logic [perf_cfg_pkg::NUM_MGR-1:0] i_gen_busy,
  output logic [perf_cfg_pkg::NUM_MGR-1:0] o_gen_start,
  output logic                             o_idle,
  output logic                             o_running
);
  import perf_cfg_pkg::*;

  run_state_e state;
  run_state_e state_next;

  always_comb begin
    state_next  = state;
    o_gen_start = '0;
    case (state)
      RUN_IDLE: begin
        if (i_start) begin
          state_next = RUN_START;
        end
      end
      RUN_START: begin
        // both managers fire together
        o_gen_start = '1;
        state_next  = RUN_WAIT;
      end
      RUN_WAIT: begin
        if (i_gen_busy == '0) begin
          state_next = RUN_IDLE;
        end
      end
      default: state_next = RUN_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= RUN_IDLE;
    end else begin
      state <= state_next;
    end
  end

  assign o_idle    = (state == RUN_IDLE);
  assign o_running = (state != RUN_IDLE);

endmodule

// File: src/burst_wr_gen.sv
`timescale 1ns/1ps

module burst_wr_gen #(
  parameter logic [axi_wr_pkg::AXI_ADDR_W-1:0] BASE_ADDR = '0,
  parameter int                                MGR_IDX   = 0
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   i_start,
  input  perf_cfg_pkg::gen_cfg_t i_cfg,
  output logic                   o_busy,
  output logic                   o_awvalid,
  output axi_wr_pkg::aw_beat_t   o_aw,
  input  logic                   i_awready,
  output logic                   o_wvalid,
  output axi_wr_pkg::w_beat_t    o_w,
  input  logic                   i_wready,
  input  logic                   i_bvalid,
  input  axi_wr_pkg::b_beat_t    i_b,
  output logic                   o_bready
);
  import perf_cfg_pkg::*;
  import axi_wr_pkg::*;

  typedef enum logic [1:0] {
    GEN_IDLE,
    GEN_AW,
    GEN_W,
    GEN_B
  } gen_state_e;

  gen_state_e            state;
  gen_cfg_t              cfg_q;
  logic [AXI_ADDR_W-1:0] addr_q;
  logic [AXI_ADDR_W-1:0] stride;
  logic [15:0]           burst_cnt;
  logic [7:0]            beat_cnt;
  logic                  w_last;
  logic                  b_hit;

  assign stride = AXI_ADDR_W'(cfg_q.burst_beats) * AXI_ADDR_W'(STRB_W);
  assign w_last = (beat_cnt == o_aw.len);
  assign b_hit  = i_bvalid && (i_b.id[MGR_ID_W-1:0] == MGR_ID_W'(MGR_IDX));

  // ------------------------------
  // burst sequencing
  // ------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= GEN_IDLE;
      burst_cnt <= '0;
      beat_cnt  <= '0;
    end else begin
      case (state)
        GEN_IDLE: begin
          if (i_start && i_cfg.burst_num != '0) begin
            state     <= GEN_AW;
            burst_cnt <= '0;
          end
        end
        GEN_AW: begin
          if (i_awready) begin
            state    <= GEN_W;
            beat_cnt <= '0;
          end
        end
        GEN_W: begin
          if (i_wready && w_last) begin
            state <= GEN_B;
          end else if (i_wready) begin
            beat_cnt <= beat_cnt + 8'd1;
          end
        end
        GEN_B: begin
          if (b_hit) begin
            burst_cnt <= burst_cnt + 16'd1;
            state     <= (burst_cnt == cfg_q.burst_num - 16'd1) ? GEN_IDLE : GEN_AW;
          end
        end
        default: state <= GEN_IDLE;
      endcase
    end
  end

  // config and address follow the run
  always_ff @(posedge clk) begin
    if (state == GEN_IDLE && i_start) begin
      cfg_q  <= i_cfg;
      addr_q <= BASE_ADDR;
    end else if (state == GEN_B && b_hit) begin
      addr_q <= addr_q + stride;
    end
  end

  assign o_busy    = (state != GEN_IDLE);
  assign o_awvalid = (state == GEN_AW);
  assign o_wvalid  = (state == GEN_W);
  // one burst in flight, so a response can always be taken
  assign o_bready  = 1'b1;

  assign o_aw.addr  = addr_q;
  assign o_aw.id    = AXI_ID_W'(MGR_IDX);
  assign o_aw.len   = cfg_q.burst_beats - 8'd1;
  assign o_aw.size  = MAX_AWSIZE;
  assign o_aw.burst = BURST_INCR;

  // manager index on top, beat number below
  assign o_w.data = {1'(MGR_IDX), (AXI_DATA_W-1)'(beat_cnt)};
  assign o_w.strb = '1;
  assign o_w.last = w_last;

endmodule

// File: src/wr_arbiter.sv
`timescale 1ns/1ps

module wr_arbiter (
  input  logic                                                  clk,
  input  logic                                                  rst_n,
  input  logic                 [perf_cfg_pkg::NUM_MGR-1:0]      i_awvalid,
  input  axi_wr_pkg::aw_beat_t [perf_cfg_pkg::NUM_MGR-1:0]      i_aw,
  output logic                 [perf_cfg_pkg::NUM_MGR-1:0]      o_awready,
  input  logic                 [perf_cfg_pkg::NUM_MGR-1:0]      i_wvalid,
  input  axi_wr_pkg::w_beat_t  [perf_cfg_pkg::NUM_MGR-1:0]      i_w,
  output logic                 [perf_cfg_pkg::NUM_MGR-1:0]      o_wready,
  output logic                 [perf_cfg_pkg::NUM_MGR-1:0]      o_bvalid,
  output axi_wr_pkg::b_beat_t  [perf_cfg_pkg::NUM_MGR-1:0]      o_b,
  input  logic                 [perf_cfg_pkg::NUM_MGR-1:0]      i_bready,
  output logic                                                  o_awvalid,
  output axi_wr_pkg::aw_beat_t                                  o_aw,
  input  logic                                                  i_awready,
  output logic                                                  o_wvalid,
  output axi_wr_pkg::w_beat_t                                   o_w,
  input  logic                                                  i_wready,
  input  logic                                                  i_bvalid,
  input  axi_wr_pkg::b_beat_t                                   i_b,
  output logic                                                  o_bready
);
  import perf_cfg_pkg::*;
  import axi_wr_pkg::*;

  logic aw_act;
  logic aw_sel;
  logic w_open;
  logic w_sel;
  logic pick;
  logic b_sel;

  // w_sel doubles as the last manager served
  assign pick = i_awvalid[~w_sel] ? ~w_sel : w_sel;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      aw_act <= 1'b0;
      aw_sel <= 1'b0;
      w_open <= 1'b0;
      w_sel  <= 1'b1;
    end else begin
      // no new grant while a data burst is open
      if (!aw_act && !w_open && |i_awvalid) begin
        aw_act <= 1'b1;
        aw_sel <= pick;
      end
      if (o_awvalid && i_awready) begin
        aw_act <= 1'b0;
        w_open <= 1'b1;
        w_sel  <= aw_sel;
      end
      if (o_wvalid && i_wready && o_w.last) begin
        w_open <= 1'b0;
      end
    end
  end

  always_comb begin
    o_awvalid = aw_act && i_awvalid[aw_sel];
    o_aw      = i_aw[aw_sel];
    o_aw.id[AXI_ID_W-1] = aw_sel;
    o_awready = '0;
    o_awready[aw_sel] = aw_act && i_awready;

    o_wvalid = w_open && i_wvalid[w_sel];
    o_w      = i_w[w_sel];
    o_wready = '0;
    o_wready[w_sel] = w_open && i_wready;

    // responses go back by the top id bit
    b_sel    = i_b.id[AXI_ID_W-1];
    o_bready = i_bready[b_sel];
    for (int i = 0; i < NUM_MGR; i++) begin
      o_bvalid[i] = i_bvalid && (b_sel == 1'(i));
      o_b[i]      = i_b;
      o_b[i].id[AXI_ID_W-1] = 1'b0;
    end
  end

endmodule

// File: src/wr_stats.sv
`timescale 1ns/1ps

module wr_stats (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     i_start,
  input  logic                     i_running,
  input  logic                     i_bvalid,
  input  logic                     i_bready,
  input  logic                     i_wvalid,
  input  logic                     i_wready,
  output perf_cfg_pkg::run_stats_t o_stats
);
  import perf_cfg_pkg::*;

  logic b_fire;
  logic w_fire;

  // counters stick at all ones
  function automatic logic [STAT_W-1:0] sat_inc(
    input logic [STAT_W-1:0] val,
    input logic              en
  );
    logic [STAT_W-1:0] res;
    res = val;
    if (en && val != '1) begin
      res = val + STAT_W'(1);
    end
    return res;
  endfunction

  assign b_fire = i_bvalid && i_bready;
  assign w_fire = i_wvalid && i_wready;

  // ------------------------------
  // external port counters
  // ------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_stats <= '0;
    end else if (i_start) begin
      o_stats <= '0;
    end else begin
      o_stats.bursts <= sat_inc(o_stats.bursts, b_fire);
      o_stats.beats  <= sat_inc(o_stats.beats, w_fire);
      o_stats.cycles <= sat_inc(o_stats.cycles, i_running);
    end
  end

endmodule

// File: src/axi_perf_top.sv
`timescale 1ns/1ps

module axi_perf_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   i_reg_req,
  input  perf_cfg_pkg::reg_req_t i_reg_req_data,
  output logic                   o_reg_ack,
  output perf_cfg_pkg::reg_rsp_t o_reg_rsp,
  output logic                   o_awvalid,
  output axi_wr_pkg::aw_beat_t   o_aw,
  input  logic                   i_awready,
  output logic                   o_wvalid,
  output axi_wr_pkg::w_beat_t    o_w,
  input  logic                   i_wready,
  input  logic                   i_bvalid,
  input  axi_wr_pkg::b_beat_t    i_b,
  output logic                   o_bready
);
  import perf_cfg_pkg::*;
  import axi_wr_pkg::*;

  // each manager gets an equal slice of the address space
  localparam int unsigned MGR_SPAN = (2 ** AXI_ADDR_W) / NUM_MGR;

  logic                   start;
  logic                   idle;
  logic                   running;
  gen_cfg_t               cfg;
  run_stats_t             stats;
  logic     [NUM_MGR-1:0] gen_start;
  logic     [NUM_MGR-1:0] gen_busy;
  logic     [NUM_MGR-1:0] m_awvalid;
  aw_beat_t [NUM_MGR-1:0] m_aw;
  logic     [NUM_MGR-1:0] m_awready;
  logic     [NUM_MGR-1:0] m_wvalid;
  w_beat_t  [NUM_MGR-1:0] m_w;
  logic     [NUM_MGR-1:0] m_wready;
  logic     [NUM_MGR-1:0] m_bvalid;
  b_beat_t  [NUM_MGR-1:0] m_b;
  logic     [NUM_MGR-1:0] m_bready;

  perf_ctrl_regs u_regs (
    .clk            (clk),
    .rst_n          (rst_n),
    .i_reg_req      (i_reg_req),
    .i_reg_req_data (i_reg_req_data),
    .o_reg_ack      (o_reg_ack),
    .o_reg_rsp      (o_reg_rsp),
    .i_idle         (idle),
    .i_stats        (stats),
    .o_start        (start),
    .o_cfg          (cfg)
  );

  perf_sequencer u_seq (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_start     (start),
    .i_gen_busy  (gen_busy),
    .o_gen_start (gen_start),
    .o_idle      (idle),
    .o_running   (running)
  );

  for (genvar i = 0; i < NUM_MGR; i++) begin : g_gen
    burst_wr_gen #(
      .BASE_ADDR (AXI_ADDR_W'(i * MGR_SPAN)),
      .MGR_IDX   (i)
    ) u_gen (
      .clk       (clk),
      .rst_n     (rst_n),
      .i_start   (gen_start[i]),
      .i_cfg     (cfg),
      .o_busy    (gen_busy[i]),
      .o_awvalid (m_awvalid[i]),
      .o_aw      (m_aw[i]),
      .i_awready (m_awready[i]),
      .o_wvalid  (m_wvalid[i]),
      .o_w       (m_w[i]),
      .i_wready  (m_wready[i]),
      .i_bvalid  (m_bvalid[i]),
      .i_b       (m_b[i]),
      .o_bready  (m_bready[i])
    );
  end

  wr_arbiter u_arb (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_awvalid (m_awvalid),
    .i_aw      (m_aw),
    .o_awready (m_awready),
    .i_wvalid  (m_wvalid),
    .i_w       (m_w),
    .o_wready  (m_wready),
    .o_bvalid  (m_bvalid),
    .o_b       (m_b),
    .i_bready  (m_bready),
    .o_awvalid (o_awvalid),
    .o_aw      (o_aw),
    .i_awready (i_awready),
    .o_wvalid  (o_wvalid),
    .o_w       (o_w),
    .i_wready  (i_wready),
    .i_bvalid  (i_bvalid),
    .i_b       (i_b),
    .o_bready  (o_bready)
  );

  // stats watch the external port
  wr_stats u_stats (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_start   (start),
    .i_running (running),
    .i_bvalid  (i_bvalid),
    .i_bready  (o_bready),
    .i_wvalid  (o_wvalid),
    .i_wready  (i_wready),
    .o_stats   (stats)
  );

endmodule

// File: tests/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// ------------------------------
// compare tasks
// ------------------------------
task automatic check_aw(input string name, input aw_beat_t expected, input aw_beat_t actual);
  if (actual !== expected) begin
    $display("ERR %s: expected %h, actual %h", name, expected, actual);
    stop_fail();
  end
endtask

task automatic check_w(input string name, input w_beat_t expected, input w_beat_t actual);
  if (actual !== expected) begin
    $display("ERR %s: expected %h, actual %h", name, expected, actual);
    stop_fail();
  end
endtask

task automatic check_rsp(input string name, input reg_rsp_t expected, input reg_rsp_t actual);
  if (actual !== expected) begin
    $display("ERR %s: expected %h, actual %h", name, expected, actual);
    stop_fail();
  end
endtask

task automatic check_stat(input string name, input logic [STAT_W-1:0] expected,
                          input logic [STAT_W-1:0] actual);
  if (actual !== expected) begin
    $display("ERR %s: expected %0d, actual %0d", name, expected, actual);
    stop_fail();
  end
endtask

task automatic check_bit(input string name, input logic expected, input logic actual);
  if (actual !== expected) begin
    $display("ERR %s: expected %b, actual %b", name, expected, actual);
    stop_fail();
  end
endtask

// ------------------------------
// register port
// ------------------------------
task automatic wait_ack(input logic level);
  int n;
  n = 0;
  while (o_reg_ack !== level) begin
    if (n == ACK_LIMIT) begin
      $display("register ack did not go to %b within %0d cycles", level, ACK_LIMIT);
      stop_fail();
    end
    n++;
    @(negedge clk);
  end
endtask

// one full four-phase exchange
task automatic reg_access(input reg_op_e op, input logic [REG_ADDR_W-1:0] addr,
                          input logic [REG_DATA_W-1:0] wdata, output reg_rsp_t rsp);
  @(negedge clk);
  i_reg_req_data = '{op: op, addr: addr, wdata: wdata};
  i_reg_req      = 1'b1;
  wait_ack(1'b1);
  rsp       = o_reg_rsp;
  i_reg_req = 1'b0;
  wait_ack(1'b0);
endtask

// writes answer with zero data
task automatic reg_expect(input reg_op_e op, input logic [REG_ADDR_W-1:0] addr,
                          input logic [REG_DATA_W-1:0] data, input reg_rsp_e code,
                          input string name);
  reg_rsp_t rsp;
  reg_rsp_t want;
  reg_access(op, addr, (op == OP_WRITE) ? data : '0, rsp);
  want.code  = code;
  want.rdata = (op == OP_READ) ? data : '0;
  check_rsp(name, want, rsp);
endtask

task automatic read_reg(input logic [REG_ADDR_W-1:0] addr, input string name,
                        output logic [REG_DATA_W-1:0] data);
  reg_rsp_t rsp;
  reg_access(OP_READ, addr, '0, rsp);
  if (rsp.code !== RSP_OK) begin
    $display("ERR %s: expected code %0d, actual %0d", name, RSP_OK, rsp.code);
    stop_fail();
  end
  data = rsp.rdata;
endtask

`endif

// File: tests/tb_axi_perf.sv
`timescale 1ns/1ps

module tb_axi_perf;
  import perf_cfg_pkg::*;
  import axi_wr_pkg::*;

  localparam int ACK_LIMIT = 10;
  localparam int RUN_LIMIT = 500;
  localparam logic [AXI_ADDR_W-1:0] HALF_SPAN = AXI_ADDR_W'(1 << (AXI_ADDR_W - 1));

  logic     clk;
  logic     rst_n;
  logic     i_reg_req;
  reg_req_t i_reg_req_data;
  logic     o_reg_ack;
  reg_rsp_t o_reg_rsp;
  logic     o_awvalid;
  aw_beat_t o_aw;
  logic     i_awready = 1'b0;
  logic     o_wvalid;
  w_beat_t  o_w;
  logic     i_wready = 1'b0;
  logic     i_bvalid = 1'b0;
  b_beat_t  i_b = '0;
  logic     o_bready;

  integer seed = 32'h1e95;

  // expected traffic per manager
  aw_beat_t            exp_aw0[$];
  aw_beat_t            exp_aw1[$];
  w_beat_t             exp_w0[$];
  w_beat_t             exp_w1[$];
  logic [AXI_ID_W-1:0] aw_order[$];
  logic [AXI_ID_W-1:0] b_ids[$];
  int                  b_wait = 0;
  int                  b_seen = 0;
  logic [7:0]          beats_a;
  logic [7:0]          beats_b;
  logic [15:0]         num_a;
  logic [15:0]         num_b;

  task automatic stop_fail();
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  `include "tb_checks.svh"

  axi_perf_top dut (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ------------------------------
  // reference model
  // ------------------------------
  task automatic build_model(input logic [7:0] beats, input logic [15:0] num);
    aw_beat_t aw;
    w_beat_t  w;
    exp_aw0.delete();
    exp_aw1.delete();
    exp_w0.delete();
    exp_w1.delete();
    b_seen = 0;
    for (int m = 0; m < NUM_MGR; m++) begin
      for (int k = 0; k < int'(num); k++) begin
        aw.addr  = (m == 1) ? HALF_SPAN : '0;
        aw.addr  = aw.addr + AXI_ADDR_W'(k * int'(beats) * (AXI_DATA_W / 8));
        aw.id    = AXI_ID_W'((m << (AXI_ID_W - 1)) | m);
        aw.len   = beats - 8'd1;
        aw.size  = 3'($clog2(AXI_DATA_W / 8));
        aw.burst = 2'b01;
        if (m == 1) exp_aw1.push_back(aw);
        else exp_aw0.push_back(aw);
        for (int j = 0; j < int'(beats); j++) begin
          w.data = AXI_DATA_W'((m << (AXI_DATA_W - 1)) | j);
          w.strb = '1;
          w.last = (j == int'(beats) - 1);
          if (m == 1) exp_w1.push_back(w);
          else exp_w0.push_back(w);
        end
      end
    end
  endtask

  task automatic take_aw(input aw_beat_t act);
    aw_beat_t want;
    logic     mgr;
    mgr = act.id[AXI_ID_W-1];
    if ((mgr && exp_aw1.size() == 0) || (!mgr && exp_aw0.size() == 0)) begin
      $display("manager %0d issued more bursts than configured", mgr);
      stop_fail();
    end
    if (mgr) want = exp_aw1.pop_front();
    else want = exp_aw0.pop_front();
    check_aw($sformatf("aw manager %0d", mgr), want, act);
    aw_order.push_back(act.id);
  endtask

  // data follows the order in which addresses were accepted
  task automatic take_w(input w_beat_t act);
    w_beat_t             want;
    logic [AXI_ID_W-1:0] id;
    if (aw_order.size() == 0) begin
      $display("write data beat seen with no accepted address");
      stop_fail();
    end
    id = aw_order[0];
    if (id[AXI_ID_W-1]) want = exp_w1.pop_front();
    else want = exp_w0.pop_front();
    check_w($sformatf("w manager %0d", id[AXI_ID_W-1]), want, act);
    if (act.last) begin
      b_ids.push_back(aw_order.pop_front());
    end
  endtask

  // memory side, sampled before the coming rising edge
  always @(negedge clk) begin
    if (i_bvalid === 1'b1 && o_bready === 1'b1) begin
      b_ids.delete(0);
      b_seen   = b_seen + 1;
      i_bvalid = 1'b0;
      b_wait   = int'($unsigned($random(seed)) % 4);
    end else if (i_bvalid !== 1'b1 && b_ids.size() != 0) begin
      if (b_wait == 0) begin
        i_b      = '{id: b_ids[0], resp: 2'b00};
        i_bvalid = 1'b1;
      end else begin
        b_wait = b_wait - 1;
      end
    end
    i_awready = rst_n && ($random(seed) % 4 != 0);
    i_wready  = rst_n && ($random(seed) % 3 != 0);
    if (o_awvalid === 1'b1 && i_awready === 1'b1) take_aw(o_aw);
    if (o_wvalid === 1'b1 && i_wready === 1'b1) take_w(o_w);
  end

  task automatic run_once(input logic [7:0] beats, input logic [15:0] num, input string tag);
    logic [REG_DATA_W-1:0] val;
    logic [STAT_W-1:0]     total;
    int                    polls;
    total = STAT_W'(2 * int'(num) * int'(beats));
    reg_expect(OP_WRITE, REG_BURST_BEATS, 32'(beats), RSP_OK, {tag, " beats"});
    reg_expect(OP_WRITE, REG_BURST_NUM, 32'(num), RSP_OK, {tag, " bursts"});
    build_model(beats, num);
    reg_expect(OP_WRITE, REG_START, 32'd1, RSP_OK, {tag, " start"});
    reg_expect(OP_WRITE, REG_START, 32'd1, RSP_ERR, {tag, " start while running"});
    reg_expect(OP_READ, REG_IDLE, 32'd0, RSP_OK, {tag, " idle while running"});
    reg_expect(OP_READ, REG_START, 32'd1, RSP_OK, {tag, " start flag"});
    polls = 0;
    read_reg(REG_IDLE, {tag, " idle poll"}, val);
    while (val != 32'd1) begin
      if (polls == RUN_LIMIT) begin
        $display("%s did not return to idle within %0d register polls", tag, RUN_LIMIT);
        stop_fail();
      end
      polls++;
      read_reg(REG_IDLE, {tag, " idle poll"}, val);
    end
    check_stat({tag, " responses at idle"}, STAT_W'(2 * int'(num)), STAT_W'(b_seen));
    if (exp_aw0.size() + exp_aw1.size() + exp_w0.size() + exp_w1.size() != 0) begin
      $display("%s went idle with bursts or beats still expected", tag);
      stop_fail();
    end
    read_reg(REG_STAT_BURSTS, {tag, " stat bursts"}, val);
    check_stat({tag, " stat bursts"}, STAT_W'(2 * int'(num)), val);
    read_reg(REG_STAT_BEATS, {tag, " stat beats"}, val);
    check_stat({tag, " stat beats"}, total, val);
    read_reg(REG_STAT_CYCLES, {tag, " stat cycles"}, val);
    if (val < total) begin
      $display("ERR %s stat cycles: expected at least %0d, actual %0d", tag, total, val);
      stop_fail();
    end
    reg_expect(OP_READ, REG_START, 32'd0, RSP_OK, {tag, " start flag cleared"});
  endtask

  // ------------------------------
  // test sequence
  // ------------------------------
  initial begin
    beats_a = 8'(($unsigned($random(seed)) % 13) + 4);
    num_a   = 16'(($unsigned($random(seed)) % 4) + 2);
    beats_b = 8'(($unsigned($random(seed)) % 13) + 4);
    num_b   = 16'(($unsigned($random(seed)) % 4) + 2);
    rst_n          = 1'b0;
    i_reg_req      = 1'b0;
    i_reg_req_data = '0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    check_bit("reset awvalid", 1'b0, o_awvalid);
    check_bit("reset wvalid", 1'b0, o_wvalid);
    check_bit("reset reg ack", 1'b0, o_reg_ack);
    check_bit("reset bready", 1'b1, o_bready);
    reg_expect(OP_READ, REG_IDLE, 32'd1, RSP_OK, "reset idle");
    reg_expect(OP_READ, REG_START, 32'd0, RSP_OK, "reset start");
    reg_expect(OP_READ, REG_BURST_BEATS, 32'd16, RSP_OK, "reset beats");
    reg_expect(OP_READ, REG_BURST_NUM, 32'd4, RSP_OK, "reset bursts");
    reg_expect(OP_READ, REG_STAT_BURSTS, 32'd0, RSP_OK, "reset stat bursts");
    reg_expect(OP_READ, REG_STAT_BEATS, 32'd0, RSP_OK, "reset stat beats");
    reg_expect(OP_READ, REG_STAT_CYCLES, 32'd0, RSP_OK, "reset stat cycles");

    reg_expect(OP_WRITE, REG_BURST_BEATS, 32'(beats_a), RSP_OK, "write beats");
    reg_expect(OP_WRITE, REG_BURST_NUM, 32'(num_a), RSP_OK, "write bursts");
    reg_expect(OP_READ, REG_BURST_BEATS, 32'(beats_a), RSP_OK, "read beats");
    reg_expect(OP_READ, REG_BURST_NUM, 32'(num_a), RSP_OK, "read bursts");
    reg_expect(OP_WRITE, REG_IDLE, 32'd1, RSP_ERR, "write idle");
    reg_expect(OP_WRITE, 4'hf, 32'h5a, RSP_ERR, "write addr 15");
    reg_expect(OP_READ, 4'hf, 32'd0, RSP_ERR, "read addr 15");
    reg_expect(OP_READ, REG_BURST_BEATS, 32'(beats_a), RSP_OK, "beats after errors");

    // second run proves the counters clear at start
    run_once(beats_a, num_a, "run 1");
    run_once(beats_b, num_b, "run 2");

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// File: vlog.f
+incdir+tests
src/perf_cfg_pkg.sv
src/axi_wr_pkg.sv
src/perf_ctrl_regs.sv
src/perf_sequencer.sv
src/burst_wr_gen.sv
src/wr_arbiter.sv
src/wr_stats.sv
src/axi_perf_top.sv
tests/tb_axi_perf.sv

// File: Makefile
VERILATOR ?= verilator
BUILD_DIR ?= build
LOG       ?= sim.log
TOP       ?= tb_axi_perf
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build $(TOP) with Verilator, run it into $(LOG), check the result"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR BUILD_DIR LOG"

test:
	$(VERILATOR) $(VFLAGS) -f vlog.f --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG) || (echo "test failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
